// File: source/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // rv32i major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP       = 7'b0110011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_AUIPC    = 7'b0010111,
        OPC_LUI      = 7'b0110111,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [3:0] {
        S_RESET   = 4'd0,
        S_FETCH   = 4'd1,
        S_DECODE  = 4'd2,
        S_EXEC    = 4'd3,
        S_LOAD2   = 4'd4,
        S_STORE2  = 4'd5,
        S_BRANCH2 = 4'd6,
        S_HALT    = 4'd7
    } state_e;

    // branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam word_t INSTR_LEN = 32'd4;

endpackage

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t   result,
    output logic             lt,
    output logic             ltu,
    output logic             eq
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // compare flags, used by slt/sltu and by branches
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;
    assign eq  = a == b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'd0, lt};
            ALU_SLTU: result = {31'd0, ltu};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

// File: source/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic               clk,
    input  logic               reset,
    input  logic               ir_load,
    input  cpu_pkg::word_t     instr,
    output cpu_pkg::opcode_e   opcode,
    output logic [2:0]         funct3,
    output cpu_pkg::reg_idx_t  rs1,
    output cpu_pkg::reg_idx_t  rs2,
    output cpu_pkg::reg_idx_t  rd,
    output cpu_pkg::word_t     imm,
    output cpu_pkg::alu_op_e   alu_op
);
    import cpu_pkg::*;

    word_t      ir;
    logic [6:0] funct7;

    // reset value is addi x0, x0, 0
    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= 32'h0000_0013;
        end else if (ir_load) begin
            ir <= instr;
        end
    end

    assign opcode = opcode_e'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign rd     = ir[11:7];

    always_comb begin
        case (opcode)
            OPC_STORE:          imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            OPC_BRANCH:         imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: imm = {ir[31:12], 12'd0};
            OPC_JAL:            imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:            imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                // funct7 bit 5 selects sub only for register-register
                3'b000:  alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

endmodule

// File: source/registers.sv
`timescale 1ns/1ps

module registers (
    input  logic              clk,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    input  cpu_pkg::reg_idx_t rd,
    input  logic              we,
    input  cpu_pkg::word_t    data,
    output cpu_pkg::word_t    val1,
    output cpu_pkg::word_t    val2
);
    import cpu_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= data;
        end
    end

    assign val1 = (rs1 == '0) ? '0 : regs[rs1];
    assign val2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: source/wb_cpu_bus.sv
`timescale 1ns/1ps

module wb_cpu_bus (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           write,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wdata,
    input  logic           wb_ack,
    input  cpu_pkg::word_t wb_rdata,
    output logic           done,
    output cpu_pkg::word_t rdata,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::word_t wb_wdata,
    output logic [3:0]     wb_sel,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we
);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (wb_cyc) begin
                // close the cycle on the edge that samples ack
                if (wb_ack) begin
                    wb_cyc <= 1'b0;
                    wb_we  <= 1'b0;
                    done   <= 1'b1;
                end
            end else if (start) begin
                wb_cyc <= 1'b1;
                wb_we  <= write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !wb_cyc) begin
            wb_adr   <= addr;
            wb_wdata <= wdata;
        end
        if (wb_cyc && wb_ack && !wb_we) begin
            rdata <= wb_rdata;
        end
    end

    assign wb_stb = wb_cyc;

    // word accesses only
    assign wb_sel = 4'b1111;

endmodule

// File: source/sequencer.sv
`timescale 1ns/1ps

module sequencer #(
    parameter cpu_pkg::word_t reset_vector = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::opcode_e  opcode,
    input  logic [2:0]        funct3,
    input  cpu_pkg::reg_idx_t rd,
    input  cpu_pkg::word_t    imm,
    input  cpu_pkg::alu_op_e  dec_alu_op,
    input  cpu_pkg::word_t    rs1_val,
    input  cpu_pkg::word_t    rs2_val,
    input  cpu_pkg::word_t    alu_result,
    input  logic              alu_lt,
    input  logic              alu_ltu,
    input  logic              alu_eq,
    input  logic              bus_done,
    input  cpu_pkg::word_t    bus_rdata,
    output cpu_pkg::word_t    alu_a,
    output cpu_pkg::word_t    alu_b,
    output cpu_pkg::alu_op_e  alu_op,
    output logic              rd_we,
    output cpu_pkg::word_t    rd_data,
    output logic              bus_start,
    output logic              bus_write,
    output cpu_pkg::word_t    bus_addr,
    output cpu_pkg::word_t    bus_wdata,
    output logic              ir_load,
    output logic              halted
);
    import cpu_pkg::*;

    state_e state;
    word_t  pc;
    word_t  pc_plus4;
    word_t  next_pc;
    word_t  req_addr;
    logic   taken;
    logic   branch_cond;
    logic   to_fetch;
    logic   is_mem;
    logic   is_store;
    logic   issue;

    // finished in exec, next step is the fetch
    always_comb begin
        case (opcode)
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
            OPC_JAL, OPC_JALR, OPC_MISC_MEM: to_fetch = 1'b1;
            default:                         to_fetch = 1'b0;
        endcase
    end

    assign is_mem   = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
    assign is_store = opcode == OPC_STORE;

    always_comb begin
        case (funct3)
            F3_BEQ:  branch_cond = alu_eq;
            F3_BNE:  branch_cond = !alu_eq;
            F3_BLT:  branch_cond = alu_lt;
            F3_BGE:  branch_cond = !alu_lt;
            F3_BLTU: branch_cond = alu_ltu;
            F3_BGEU: branch_cond = !alu_ltu;
            default: branch_cond = 1'b0;
        endcase
    end

    // decode uses the idle alu for pc + 4
    always_comb begin
        alu_a  = rs1_val;
        alu_b  = imm;
        alu_op = ALU_ADD;
        case (state)
            S_DECODE: begin
                alu_a = pc;
                alu_b = INSTR_LEN;
            end
            S_EXEC: begin
                if (opcode == OPC_AUIPC || opcode == OPC_JAL) alu_a = pc;
                if (opcode == OPC_OP || opcode == OPC_BRANCH) alu_b = rs2_val;
                if (opcode == OPC_OP || opcode == OPC_OP_IMM) alu_op = dec_alu_op;
            end
            S_BRANCH2: alu_a = pc;
            default: alu_a = rs1_val;
        endcase
    end

    always_comb begin
        case (state)
            S_EXEC: begin
                if (opcode == OPC_JAL) next_pc = alu_result;
                else if (opcode == OPC_JALR) next_pc = {alu_result[31:1], 1'b0};
                else next_pc = pc_plus4;
            end
            S_BRANCH2: next_pc = taken ? alu_result : pc_plus4;
            default:   next_pc = pc;
        endcase
    end

    assign req_addr = (state == S_EXEC && is_mem) ? alu_result : next_pc;

    always_comb begin
        case (state)
            S_RESET, S_BRANCH2: issue = 1'b1;
            S_EXEC:             issue = to_fetch || is_mem;
            S_LOAD2, S_STORE2:  issue = bus_done;
            default:            issue = 1'b0;
        endcase
    end

    always_comb begin
        rd_we   = 1'b0;
        rd_data = alu_result;
        if (state == S_EXEC) begin
            case (opcode)
                OPC_OP, OPC_OP_IMM, OPC_AUIPC: rd_we = 1'b1;
                OPC_LUI: begin
                    rd_we   = 1'b1;
                    rd_data = imm;
                end
                OPC_JAL, OPC_JALR: begin
                    rd_we   = 1'b1;
                    rd_data = pc_plus4;
                end
                default: rd_we = 1'b0;
            endcase
        end else if (state == S_LOAD2 && bus_done) begin
            rd_we   = 1'b1;
            rd_data = bus_rdata;
        end
        if (rd == '0) rd_we = 1'b0;
    end

    assign ir_load = (state == S_FETCH) && bus_done;
    assign halted  = state == S_HALT;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_RESET;
            pc        <= reset_vector;
            bus_start <= 1'b0;
            bus_write <= 1'b0;
        end else begin
            bus_start <= issue;
            if (issue) begin
                pc        <= next_pc;
                bus_write <= (state == S_EXEC) && is_store;
            end
            case (state)
                S_RESET:  state <= S_FETCH;
                S_FETCH:  if (bus_done) state <= S_DECODE;
                S_DECODE: state <= S_EXEC;
                S_EXEC: begin
                    // system and unknown opcodes stop the core
                    if (to_fetch) state <= S_FETCH;
                    else if (opcode == OPC_LOAD) state <= S_LOAD2;
                    else if (is_store) state <= S_STORE2;
                    else if (opcode == OPC_BRANCH) state <= S_BRANCH2;
                    else state <= S_HALT;
                end
                S_LOAD2, S_STORE2: if (bus_done) state <= S_FETCH;
                S_BRANCH2: state <= S_FETCH;
                default:   state <= S_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) pc_plus4 <= alu_result;
        if (state == S_EXEC) taken <= branch_cond;
        if (issue) begin
            bus_addr  <= req_addr;
            bus_wdata <= rs2_val;
        end
    end

endmodule

// File: source/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter cpu_pkg::word_t reset_vector = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           wb_ack,
    input  cpu_pkg::word_t wb_rdata,
    output cpu_pkg::word_t wb_adr,
    output cpu_pkg::word_t wb_wdata,
    output logic [3:0]     wb_sel,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output logic           halted
);
    import cpu_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1, rs2, rd;
    word_t      imm;
    alu_op_e    dec_alu_op, alu_op;
    word_t      rs1_val, rs2_val;
    word_t      alu_a, alu_b, alu_result;
    logic       alu_lt, alu_ltu, alu_eq;
    logic       rd_we, ir_load;
    word_t      rd_data;
    logic       bus_start, bus_write, bus_done;
    word_t      bus_addr, bus_wdata, bus_rdata;

    sequencer #(.reset_vector(reset_vector)) u_sequencer (
        .clk(clk), .reset(reset),
        .opcode(opcode), .funct3(funct3), .rd(rd), .imm(imm), .dec_alu_op(dec_alu_op),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alu_result(alu_result), .alu_lt(alu_lt), .alu_ltu(alu_ltu), .alu_eq(alu_eq),
        .bus_done(bus_done), .bus_rdata(bus_rdata),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op),
        .rd_we(rd_we), .rd_data(rd_data),
        .bus_start(bus_start), .bus_write(bus_write),
        .bus_addr(bus_addr), .bus_wdata(bus_wdata),
        .ir_load(ir_load), .halted(halted)
    );

    // instruction word comes straight from the bus capture register
    decoder u_decoder (
        .clk(clk), .reset(reset), .ir_load(ir_load), .instr(bus_rdata),
        .opcode(opcode), .funct3(funct3), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .alu_op(dec_alu_op)
    );

    registers u_registers (
        .clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .we(rd_we), .data(rd_data),
        .val1(rs1_val), .val2(rs2_val)
    );

    alu u_alu (
        .a(alu_a), .b(alu_b), .op(alu_op),
        .result(alu_result), .lt(alu_lt), .ltu(alu_ltu), .eq(alu_eq)
    );

    wb_cpu_bus u_bus (
        .clk(clk), .reset(reset),
        .start(bus_start), .write(bus_write), .addr(bus_addr), .wdata(bus_wdata),
        .wb_ack(wb_ack), .wb_rdata(wb_rdata),
        .done(bus_done), .rdata(bus_rdata),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_sel(wb_sel),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we)
    );

endmodule

// File: verification/cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk (
    input logic           clk,
    input logic           reset,
    input logic           wb_cyc,
    input logic           wb_stb,
    input logic           wb_ack,
    input logic           wb_we,
    input cpu_pkg::word_t wb_adr,
    input cpu_pkg::word_t wb_wdata,
    input logic           halted
);

    // cycle and strobe stay up until the slave acks
    cycle_held: assert property (@(posedge clk) disable iff (reset)
        wb_cyc && !wb_ack |=> wb_cyc && wb_stb)
        else $error("wishbone cycle dropped before ack");

    // request held until the slave acks
    request_stable: assert property (@(posedge clk) disable iff (reset)
        wb_cyc && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata))
        else $error("wishbone request changed before ack");

    no_cycle_when_halted: assert property (@(posedge clk) halted |-> !wb_cyc)
        else $error("bus cycle open while halted");

    running_after_reset: assert property (@(posedge clk) reset |=> !halted)
        else $error("halted high right after reset");

endmodule

// File: verification/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam word_t RESET_VECTOR = 32'h0000_0080;
    localparam word_t DATA_BASE    = 32'h0000_0400;
    localparam word_t STORE_BASE   = 32'h0000_0600;

    logic       clk;
    logic       reset;
    logic       wb_ack;
    word_t      wb_rdata;
    word_t      wb_adr;
    word_t      wb_wdata;
    logic [3:0] wb_sel;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic       halted;

    word_t mem [0:1023];
    word_t exp_addr [$];
    word_t exp_data [$];
    string exp_name [$];
    int    pc_w;
    int    n_instr;
    word_t slot;
    int    limit;
    int    cycles;
    int    wait_left;
    logic  in_cycle;

    cpu #(.reset_vector(RESET_VECTOR)) uut (
        .clk(clk), .reset(reset), .wb_ack(wb_ack), .wb_rdata(wb_rdata),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_sel(wb_sel),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .halted(halted)
    );

    bind cpu cpu_chk chk (
        .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
        .wb_we(wb_we), .wb_adr(wb_adr), .wb_wdata(wb_wdata), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %b actual %b", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_sel(string name, logic [3:0] expected, logic [3:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %b actual %b", name, expected, actual);
            stop_run();
        end
    endtask

    // expected value of an alu operation by the rv32i rules
    function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
        logic [4:0] sh;
        logic       slt;
        sh  = b[4:0];
        slt = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return {31'd0, slt};
            ALU_SLTU: return {31'd0, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return word_t'({{32{a[31]}}, a} >> sh);
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic ref_taken(logic [2:0] f3, word_t a, word_t b);
        logic slt;
        slt = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return slt;
            F3_BGE:  return !slt;
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [2:0] op_funct3(alu_op_e op);
        case (op)
            ALU_SLL:          return 3'b001;
            ALU_SLT:          return 3'b010;
            ALU_SLTU:         return 3'b011;
            ALU_XOR:          return 3'b100;
            ALU_SRL, ALU_SRA: return 3'b101;
            ALU_OR:           return 3'b110;
            ALU_AND:          return 3'b111;
            default:          return 3'b000;
        endcase
    endfunction

    // instruction encoders
    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_e opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t cur_pc();
        return word_t'(pc_w) << 2;
    endfunction

    task automatic put(word_t instr);
        mem[pc_w] = instr;
        pc_w++;
        n_instr++;
    endtask

    // lui plus addi with the upper part rounded for the signed low half
    task automatic load_const(reg_idx_t rd, word_t v);
        word_t hi;
        hi = v + 32'h800;
        put(enc_u(hi[31:12], rd, OPC_LUI));
        put(enc_i(v[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    // skipped stores still take a slot but are not expected
    task automatic store_word(reg_idx_t rs, logic expected, word_t value, string name);
        put(enc_s(slot[11:0], rs, 5'd0));
        if (expected) begin
            exp_addr.push_back(slot);
            exp_data.push_back(value);
            exp_name.push_back(name);
        end
        slot += 4;
    endtask

    task automatic build_program();
        word_t       a;
        word_t       b;
        word_t       v;
        word_t       p;
        logic [11:0] imm;
        logic [2:0]  f3;
        alu_op_e     op;
        logic [2:0]  conds [0:5];
        conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hc0de_0000 ^ (i << 2);
        end
        pc_w    = RESET_VECTOR >> 2;
        n_instr = 0;
        slot    = STORE_BASE;
        for (int k = 0; k < 10; k++) begin
            op = alu_op_e'(k[3:0]);
            a  = $urandom();
            b  = $urandom();
            load_const(5'd1, a);
            load_const(5'd2, b);
            put(enc_r({1'b0, op == ALU_SUB || op == ALU_SRA, 5'd0}, 5'd2, 5'd1,
                      op_funct3(op), 5'd3));
            store_word(5'd3, 1'b1, ref_alu(op, a, b), {"reg ", op.name()});
            if (op != ALU_SUB) begin
                imm = 12'($urandom());
                if (op == ALU_SLL || op == ALU_SRL) imm[11:5] = 7'd0;
                if (op == ALU_SRA) imm[11:5] = 7'b0100000;
                put(enc_i(imm, 5'd1, op_funct3(op), 5'd4, OPC_OP_IMM));
                store_word(5'd4, 1'b1, ref_alu(op, a, {{20{imm[11]}}, imm}),
                           {"imm ", op.name()});
            end
        end
        v = $urandom();
        p = cur_pc();
        put(enc_u(v[31:12], 5'd5, OPC_AUIPC));
        store_word(5'd5, 1'b1, p + {v[31:12], 12'd0}, "auipc");
        p = cur_pc();
        put(enc_j(21'd8, 5'd6));
        store_word(5'd0, 1'b0, 32'd0, "jal skip");
        store_word(5'd6, 1'b1, p + 32'd4, "jal link");
        // jalr target has bit 0 set for the core to clear
        p = cur_pc();
        put(enc_i(p[11:0] + 12'd12, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
        put(enc_i(12'd1, 5'd7, 3'b000, 5'd8, OPC_JALR));
        store_word(5'd0, 1'b0, 32'd0, "jalr skip");
        store_word(5'd8, 1'b1, p + 32'd8, "jalr link");
        for (int r = 0; r < 12; r++) begin
            f3 = conds[r % 6];
            a  = $urandom();
            b  = ($urandom_range(1, 0) == 0) ? a : $urandom();
            load_const(5'd1, a);
            load_const(5'd2, b);
            put(enc_b(13'd8, 5'd2, 5'd1, f3));
            store_word(5'd1, !ref_taken(f3, a, b), a, $sformatf("branch f3 %b", f3));
        end
        for (int i = 0; i < 8; i++) begin
            v = DATA_BASE + 32'(i * 4);
            mem[v[11:2]] = $urandom();
            put(enc_i(v[11:0], 5'd0, 3'b010, 5'd9, OPC_LOAD));
            store_word(5'd9, 1'b1, mem[v[11:2]], $sformatf("lw %0d", i));
        end
        // ecall
        put(32'h0000_0073);
    endtask

    // wishbone memory with 0 to 3 wait cycles per transfer
    always @(posedge clk) begin
        #1;
        wb_ack = 1'b0;
        if (reset || !wb_cyc) begin
            in_cycle = 1'b0;
        end else begin
            if (!in_cycle) begin
                in_cycle  = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                wb_ack = 1'b1;
                if (wb_we) mem[wb_adr[11:2]] = wb_wdata;
                else wb_rdata = mem[wb_adr[11:2]];
            end else begin
                wait_left--;
            end
        end
    end

    always @(negedge clk) begin
        if (wb_cyc && wb_ack) begin
            check_sel("byte select", 4'b1111, wb_sel);
        end
        if (wb_cyc && wb_stb && wb_ack && wb_we) begin
            if (exp_addr.size() == 0) begin
                $display("unexpected store of %h to address %h", wb_wdata, wb_adr);
                stop_run();
            end else begin
                check_word({exp_name[0], " address"}, exp_addr.pop_front(), wb_adr);
                check_word(exp_name.pop_front(), exp_data.pop_front(), wb_wdata);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles > limit) begin
                $display("timeout, the core did not halt within %0d cycles", limit);
                stop_run();
            end
        end
    end

    initial begin
        void'($urandom(32'hf212_b949));
        reset     = 1'b1;
        wb_ack    = 1'b0;
        wb_rdata  = '0;
        in_cycle  = 1'b0;
        wait_left = 0;
        cycles    = 0;
        build_program();
        limit = 40 * n_instr;
        repeat (8) @(posedge clk);
        #1;
        check_bit("cyc in reset", 1'b0, wb_cyc);
        check_bit("halted in reset", 1'b0, halted);
        reset = 1'b0;
        while (!wb_cyc) @(negedge clk);
        check_word("first fetch", RESET_VECTOR, wb_adr);
        while (!halted) @(negedge clk);
        repeat (20) begin
            @(negedge clk);
            check_bit("cyc while halted", 1'b0, wb_cyc);
            check_bit("halted", 1'b1, halted);
        end
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never appeared, first is %s",
                     exp_addr.size(), exp_name[0]);
            stop_run();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: files.f
source/cpu_pkg.sv
source/alu.sv
source/decoder.sv
source/registers.sv
source/wb_cpu_bus.sv
source/sequencer.sv
source/cpu.sv
verification/cpu_chk.sv
verification/tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
